//--- design/jacobiPkg.sv
// Shared widths, grid size, bus addresses and types for the Jacobi array.
// The RTL and the testbench both import this package.
// Grid and counter sizes here are only defaults. The top level passes
// its own values down to the controller and the cell array.
`default_nettype none

package jacobiPkg;

   // Cell and bus widths
   localparam int CellWidth = 8;
   localparam int DataWidth = 32;
   localparam int AddrWidth = 15;

   // Default array geometry
   localparam int GridRows = 8;
   localparam int GridCols = 8;

   localparam int CountWidth = 7;   // Up to 127 iterations per counter write

   // One cell of the grid
   typedef logic [CellWidth-1:0] cellT;

   // Bus payload and address
   typedef logic [DataWidth-1:0] busDataT;
   typedef logic [AddrWidth-1:0] busAddrT;

   // Register map of the bus
   localparam busAddrT ScanAddr = busAddrT'(0);    // Shifts the chain on every access
   localparam busAddrT CountAddr = busAddrT'(1);   // Iteration counter

endpackage

`default_nettype wire

//--- design/arrayCtrlIf.sv
// Link between the bus controller and the cell array.
// The controller drives the scan and update strobes.
// The array hands back the cell at the head of the scan chain.
// Both sides run on the same clock.
`default_nettype none

interface arrayCtrlIf
   import jacobiPkg::*;
();

   bit shift;       // Chain moves one place this clock
   cellT shiftIn;   // Enters the tail cell on a shift
   bit step;        // One relaxation update this clock

   // Row 0 column 0, straight from its register
   cellT head;

   // Controller side
   modport control
   (
      output shift,
      output shiftIn,
      output step,
      input head
   );

   // Array side, a shift takes priority over a step here
   modport array
   (
      input shift,
      input shiftIn,
      input step,
      output head
   );

endinterface

`default_nettype wire

//--- design/jacobiControl.sv
// Bus front end of the Jacobi array.
// Decodes the scan port and the iteration counter, paces the relaxation
// steps from the counter and drives the scan chain.
// Read data is registered and appears one clock after the read strobe.
`default_nettype none

module jacobiControl
   import jacobiPkg::*;
#(
   parameter int CountWidth = jacobiPkg::CountWidth   // Iteration counter width
)
(
   input wire Clk,
   input wire reset,
   input wire rd,               // Read strobe
   input wire wr,               // Write strobe
   input wire busAddrT addr,
   input wire busDataT dataIn,
   output busDataT dataOut,     // Registered read data
   arrayCtrlIf.control ctrl
);

   logic scanSel;
   logic countSel;
   logic countWrite;
   logic [CountWidth-1:0] count;   // Updates still to run
   busDataT readNext;

   // Address decode
   assign scanSel = (addr == ScanAddr);
   assign countSel = (addr == CountAddr);
   assign countWrite = wr && countSel;

   // Every access to the scan port moves the chain by one cell
   assign ctrl.shift = (rd || wr) && scanSel;

   // A write feeds its low byte in at the tail, a read feeds zero
   assign ctrl.shiftIn = wr ? dataIn[CellWidth-1:0] : '0;

   // Iteration counter
   always_ff @(posedge Clk)
   begin
      if (reset)
         count <= '0;
      else if (countWrite)
         count <= dataIn[CountWidth-1:0];   // A new write reloads, even mid run
      else if (count != '0)
         count <= count - 1'b1;
   end

   // One grid update for each remaining count
   assign ctrl.step = (count != '0);

   // Read mux
   always_comb
   begin
      if (scanSel)
         readNext = busDataT'(ctrl.head);   // Value leaving the head on this edge
      else if (countSel)
         readNext = busDataT'(count);       // Remaining iterations
      else
         readNext = '0;                     // Unmapped
   end

   // Read data register, held until the next read
   always_ff @(posedge Clk)
   begin
      if (reset)
         dataOut <= '0;
      else if (rd)
         dataOut <= readNext;
   end

endmodule

`default_nettype wire

//--- design/jacobiArray.sv
// Grid of cell registers for the Jacobi relaxation.
// A scan shift moves every cell one place toward cell 0 and loads the tail.
// A step replaces each interior cell by the floor of the mean of its four
// neighbours, all cells at once. Boundary cells only move on a scan shift.
// Cells are numbered row * Cols + column, and cell 0 is the head.
`default_nettype none

module jacobiArray
   import jacobiPkg::*;
#(
   parameter int Rows = GridRows,
   parameter int Cols = GridCols
)
(
   input wire Clk,
   input wire reset,
   arrayCtrlIf.array ctrl
);

   localparam int Cells = Rows * Cols;
   localparam int SumWidth = CellWidth + 2;   // Four cells never overflow this

   cellT cells [Cells];         // Current grid
   cellT chainNext [Cells];     // Grid after one scan shift
   cellT stencilNext [Cells];   // Grid after one relaxation update

   genvar r;
   genvar c;

   for (r = 0; r < Rows; r++)
   begin : gRow
      for (c = 0; c < Cols; c++)
      begin : gCol
         localparam int Idx = r * Cols + c;
         localparam bit OnEdge = (r == 0) || (r == Rows - 1)
                                 || (c == 0) || (c == Cols - 1);

         // Chain successor of this cell
         if (Idx == Cells - 1)
         begin : gTail
            assign chainNext[Idx] = ctrl.shiftIn;
         end
         else
         begin : gLink
            assign chainNext[Idx] = cells[Idx + 1];
         end

         if (OnEdge)
         begin : gFixed
            assign stencilNext[Idx] = cells[Idx];   // Boundary holds its value
         end
         else
         begin : gInner
            logic [SumWidth-1:0] sum;

            // North, south, west and east, all from the previous grid
            assign sum = SumWidth'(cells[Idx - Cols])
                       + SumWidth'(cells[Idx + Cols])
                       + SumWidth'(cells[Idx - 1])
                       + SumWidth'(cells[Idx + 1]);

            // Floor of the sum over four
            assign stencilNext[Idx] = sum[SumWidth-1:2];
         end
      end
   end

   // Cell registers, a shift outranks a step
   always_ff @(posedge Clk)
   begin
      if (reset)
         cells <= '{default: '0};
      else if (ctrl.shift)
         cells <= chainNext;
      else if (ctrl.step)
         cells <= stencilNext;
   end

   assign ctrl.head = cells[0];   // Combinational from the head register

endmodule

`default_nettype wire

//--- design/jacobiTop.sv
// Top level of the Jacobi relaxation array.
// Presents the strobe bus as plain ports and joins the bus controller to
// the cell grid. Grid size and counter width default to the package values.
`default_nettype none

module jacobiTop
   import jacobiPkg::*;
#(
   parameter int Rows = GridRows,
   parameter int Cols = GridCols,
   parameter int CountWidth = jacobiPkg::CountWidth
)
(
   input wire Clk,
   input wire reset,
   input wire rd,               // Read strobe, one clock per access
   input wire wr,               // Write strobe, never with rd
   input wire busAddrT addr,
   input wire busDataT dataIn,
   output busDataT dataOut      // Read result, one clock after rd
);

   // Strobes to the grid and its head cell back
   arrayCtrlIf ctrl ();

   jacobiControl #(
      .CountWidth(CountWidth)
   ) ctrlUnit (
      .Clk(Clk),
      .reset(reset),
      .rd(rd),
      .wr(wr),
      .addr(addr),
      .dataIn(dataIn),
      .dataOut(dataOut),
      .ctrl(ctrl.control)
   );

   jacobiArray #(
      .Rows(Rows),
      .Cols(Cols)
   ) cellArray (
      .Clk(Clk),
      .reset(reset),
      .ctrl(ctrl.array)
   );

endmodule

`default_nettype wire

//--- bench/jacobiProps_props.sv
// Concurrent assertions on the bus controller of the Jacobi array.
// Bound into every jacobiControl instance, reads its internal counter.
`default_nettype none

module jacobiProps
   import jacobiPkg::*;
#(
   parameter int CountWidth = jacobiPkg::CountWidth
)
(
   input wire Clk,
   input wire reset,
   input wire rd,
   input wire wr,
   input wire busAddrT addr,
   input wire busDataT dataOut,
   input wire [CountWidth-1:0] count,
   input wire countWrite,
   input wire shift,
   input wire step
);

   timeunit 1ns;
   timeprecision 100ps;

   // Counter is cleared by reset, so no step right after it
   stepAfterReset: assert property (@(posedge Clk) reset |=> !step)
      else $error("step high in the cycle after reset");

   countDown: assert property (@(posedge Clk) disable iff (reset)
      (!countWrite && count != '0) |=> (count == $past(count) - 1'b1))
      else $error("count did not decrement by one");

   readHold: assert property (@(posedge Clk) disable iff (reset)
      !rd |=> $stable(dataOut))
      else $error("dataOut changed without a read");

   shiftDecode: assert property (@(posedge Clk)
      shift |-> ((rd || wr) && addr == ScanAddr))
      else $error("shift without a scan access");

endmodule

bind jacobiControl jacobiProps #(
   .CountWidth(CountWidth)
) props (
   .Clk(Clk),
   .reset(reset),
   .rd(rd),
   .wr(wr),
   .addr(addr),
   .dataOut(dataOut),
   .count(count),
   .countWrite(countWrite),
   .shift(ctrl.shift),
   .step(ctrl.step)
);

`default_nettype wire

//--- bench/jacobiBench.sv
// Testbench for the Jacobi relaxation array.
// Drives the strobe bus of jacobiTop through reset, scan round trips, a table
// of relaxation runs, the iteration counter and unmapped addresses.
// Expected grids come from a software model of the four-neighbour update.
`default_nettype none

module jacobiBench
   import jacobiPkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int Cells = GridRows * GridCols;
   localparam logic [15:0] LfsrSeed = 16'd48507;
   localparam logic [15:0] LfsrTaps = 16'hB400;   // x^16 + x^14 + x^13 + x^11 + 1
   localparam busAddrT UnusedAddr = busAddrT'(5);

   // Relaxation table, one run per column
   localparam int NumRuns = 6;
   localparam int IterTable [NumRuns] = '{0, 1, 2, 5, 20, 100};
   localparam bit EdgeTable [NumRuns] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};   // 1 = edges FF

   logic Clk;
   logic reset;
   logic rd;
   logic wr;
   busAddrT addr;
   busDataT dataIn;
   busDataT dataOut;

   logic [15:0] lfsrState;
   cellT loadedGrid [Cells];   // Values shifted in
   cellT expectGrid [Cells];   // Model of what the unload returns
   int errors;
   int checks;
   int cycleCount;
   int cycleLimit;

   jacobiTop dut (
      .Clk(Clk),
      .reset(reset),
      .rd(rd),
      .wr(wr),
      .addr(addr),
      .dataIn(dataIn),
      .dataOut(dataOut)
   );

   initial
   begin
      Clk = 1'b0;
      forever #4 Clk = ~Clk;
   end

   // Two full scans per run plus the iterations and some slack, doubled
   function automatic int timeoutLimit();
      int total;
      total = 0;
      for (int i = 0; i < NumRuns; i++)
         total += 2 * Cells + IterTable[i] + 10;
      return total * 2;
   endfunction

   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      if (s[0])
         return (s >> 1) ^ LfsrTaps;
      else
         return s >> 1;
   endfunction

   function automatic bit onEdge(input int k);
      int r;
      int c;
      r = k / GridCols;
      c = k % GridCols;
      return (r == 0) || (r == GridRows - 1) || (c == 0) || (c == GridCols - 1);
   endfunction

   // One LFSR step per bit
   task automatic drawCell(output cellT v);
      v = '0;
      for (int b = 0; b < CellWidth; b++)
      begin
         v = {lfsrState[0], v[CellWidth-1:1]};
         lfsrState = lfsrNext(lfsrState);
      end
   endtask

   task automatic compareWord(input string name, input busDataT got, input busDataT exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   // All bus tasks start and end 1 ns after a rising edge
   task automatic busWrite(input busAddrT a, input busDataT d);
      rd = 1'b0;
      wr = 1'b1;
      addr = a;
      dataIn = d;
      @(posedge Clk);
      #1;
      wr = 1'b0;
   endtask

   task automatic busRead(input busAddrT a, output busDataT d);
      wr = 1'b0;
      rd = 1'b1;
      addr = a;
      @(posedge Clk);
      #1;
      rd = 1'b0;
      d = dataOut;   // Registered on the edge just passed
   endtask

   task automatic idleCycles(input int n);
      repeat (n)
      begin
         @(posedge Clk);
         #1;
      end
   endtask

   task automatic fillRandom();
      for (int k = 0; k < Cells; k++)
         drawCell(loadedGrid[k]);
   endtask

   task automatic fillEdges();
      for (int k = 0; k < Cells; k++)
         loadedGrid[k] = onEdge(k) ? 8'hFF : 8'h00;
   endtask

   // Cell k goes in k-th, so it ends up in cell k
   task automatic loadGrid();
      for (int k = 0; k < Cells; k++)
         busWrite(ScanAddr, busDataT'(loadedGrid[k]));
      expectGrid = loadedGrid;
   endtask

   // Floor of the neighbour mean for interior cells, all from the old grid
   task automatic relaxModel(input int n);
      cellT next [Cells];
      int sum;
      for (int i = 0; i < n; i++)
      begin
         for (int k = 0; k < Cells; k++)
         begin
            if (onEdge(k))
               next[k] = expectGrid[k];
            else
            begin
               sum = int'(expectGrid[k - GridCols]) + int'(expectGrid[k + GridCols])
                   + int'(expectGrid[k - 1]) + int'(expectGrid[k + 1]);
               next[k] = cellT'(sum / 4);
            end
         end
         expectGrid = next;
      end
   endtask

   task automatic unloadAndCheck(input string what, input bit checkEdges);
      busDataT got;
      for (int k = 0; k < Cells; k++)
      begin
         busRead(ScanAddr, got);
         checks++;
         if (got !== busDataT'(expectGrid[k]))
         begin
            errors++;
            $display("FAILED %s cell %0d dataOut got %h expected %h",
                     what, k, got, busDataT'(expectGrid[k]));
         end
         if (checkEdges && onEdge(k) && got !== busDataT'(loadedGrid[k]))
         begin
            errors++;
            $display("FAILED %s boundary cell %0d dataOut got %h expected %h",
                     what, k, got, busDataT'(loadedGrid[k]));
         end
      end
      expectGrid = '{default: '0};   // Chain is refilled with zeros
   endtask

   always @(posedge Clk)
   begin
      cycleCount++;
      if (cycleCount > cycleLimit)
      begin
         $display("Timeout after %0d cycles, the run did not finish", cycleCount);
         $display("Checks run: %0d, errors: %0d", checks, errors + 1);
         $display("tests failed");
         $finish;
      end
   end

   initial
   begin
      busDataT got;
      errors = 0;
      checks = 0;
      cycleCount = 0;
      cycleLimit = timeoutLimit();
      lfsrState = LfsrSeed;
      reset = 1'b1;
      rd = 1'b0;
      wr = 1'b0;
      addr = '0;
      dataIn = '0;
      repeat (2) @(posedge Clk);
      #1;
      reset = 1'b0;

      // After reset
      compareWord("dataOut after reset", dataOut, '0);
      busRead(CountAddr, got);
      compareWord("dataOut count after reset", got, '0);
      expectGrid = '{default: '0};
      unloadAndCheck("reset grid", 1'b0);

      // Scan round trip, then the zeros left behind
      fillRandom();
      loadGrid();
      unloadAndCheck("round trip", 1'b0);
      unloadAndCheck("second unload", 1'b0);

      for (int i = 0; i < NumRuns; i++)
      begin
         if (EdgeTable[i])
            fillEdges();
         else
            fillRandom();
         loadGrid();
         busWrite(CountAddr, busDataT'(IterTable[i]));
         idleCycles(IterTable[i] + 2);
         relaxModel(IterTable[i]);
         unloadAndCheck($sformatf("relax %0d", IterTable[i]), 1'b1);
      end

      // Counter load, countdown and an unmapped read in between
      busWrite(CountAddr, busDataT'(20));
      busRead(CountAddr, got);
      compareWord("dataOut count next cycle", got, busDataT'(20));
      busRead(CountAddr, got);
      compareWord("dataOut count second cycle", got, busDataT'(19));
      busRead(UnusedAddr, got);
      compareWord("dataOut unmapped read", got, '0);
      idleCycles(17);
      busRead(CountAddr, got);
      compareWord("dataOut count expired", got, '0);

      // Unmapped write must not touch the grid
      fillRandom();
      loadGrid();
      busWrite(UnusedAddr, 32'hFFFF_FFAB);
      busRead(UnusedAddr, got);
      compareWord("dataOut unmapped read after write", got, '0);
      unloadAndCheck("unmapped write", 1'b1);

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
design/jacobiPkg.sv
design/arrayCtrlIf.sv
design/jacobiControl.sv
design/jacobiArray.sv
design/jacobiTop.sv
bench/jacobiProps_props.sv
bench/jacobiBench.sv

//--- run.sh
#!/bin/sh
# Build and run the Jacobi array testbench with Verilator.
# The run passes only if the simulation log holds the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module jacobiBench -f list.f -o jacobiSim > build.log 2>&1 \
   && ./obj_dir/jacobiSim > sim.log 2>&1 \
   ; grep -q "all tests passed" sim.log 2>/dev/null \
   && echo "PASS" \
   || { echo "FAIL, see build.log and sim.log"; exit 1; }
